/* Makefile */
VERILATOR ?= verilator
TOP       ?= tlb_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* filelist.f */
source/tlb_pkg.sv
source/tlb_entry_if.sv
source/tlb_entry_store.sv
source/tlb_search_port.sv
source/tlb_top.sv
testbench/tlb_sva.sv
testbench/tlb_tb.sv

/* source/tlb_entry_if.sv */
`timescale 1ns/1ps

interface tlb_entry_if #(
    parameter int tlb_num = 16
);
    import tlb_pkg::*;

    logic [tlb_num-1:0]             e;
    logic [tlb_num-1:0][vppn_w-1:0] vppn;
    logic [tlb_num-1:0][ps_w-1:0]   ps;
    logic [tlb_num-1:0][asid_w-1:0] asid;
    logic [tlb_num-1:0]             g;
    logic [tlb_num-1:0][ppn_w-1:0]  ppn0;
    logic [tlb_num-1:0][plv_w-1:0]  plv0;
    logic [tlb_num-1:0][mat_w-1:0]  mat0;
    logic [tlb_num-1:0]             d0;
    logic [tlb_num-1:0]             v0;
    logic [tlb_num-1:0][ppn_w-1:0]  ppn1;
    logic [tlb_num-1:0][plv_w-1:0]  plv1;
    logic [tlb_num-1:0][mat_w-1:0]  mat1;
    logic [tlb_num-1:0]             d1;
    logic [tlb_num-1:0]             v1;
    logic [tlb_num-1:0]             s1_vppn_hit; // From search port 1, feeds invtlb.
    logic [tlb_num-1:0]             s1_asid_hit;

    modport store (
        output e, vppn, ps, asid, g, ppn0, plv0, mat0, d0, v0, ppn1, plv1, mat1, d1, v1,
        input  s1_vppn_hit, s1_asid_hit
    );

    modport search (
        input  e, vppn, ps, asid, g, ppn0, plv0, mat0, d0, v0, ppn1, plv1, mat1, d1, v1,
        output s1_vppn_hit, s1_asid_hit
    );

endinterface

/* source/tlb_entry_store.sv */
`timescale 1ns/1ps

module tlb_entry_store #(
    parameter int tlb_num = 16
) (
    input  logic                         aclk,
    input  logic                         reset,
    tlb_entry_if.store                   ent,
    input  logic                         invtlb_valid,
    input  logic [4:0]                   invtlb_op,
    input  logic                         we,
    input  logic [$clog2(tlb_num)-1:0]   w_index,
    input  logic                         w_e,
    input  logic [tlb_pkg::vppn_w-1:0]   w_vppn,
    input  logic [tlb_pkg::ps_w-1:0]     w_ps,
    input  logic [tlb_pkg::asid_w-1:0]   w_asid,
    input  logic                         w_g,
    input  logic [tlb_pkg::ppn_w-1:0]    w_ppn0,
    input  logic [tlb_pkg::plv_w-1:0]    w_plv0,
    input  logic [tlb_pkg::mat_w-1:0]    w_mat0,
    input  logic                         w_d0,
    input  logic                         w_v0,
    input  logic [tlb_pkg::ppn_w-1:0]    w_ppn1,
    input  logic [tlb_pkg::plv_w-1:0]    w_plv1,
    input  logic [tlb_pkg::mat_w-1:0]    w_mat1,
    input  logic                         w_d1,
    input  logic                         w_v1,
    input  logic [$clog2(tlb_num)-1:0]   r_index,
    output logic                         r_e,
    output logic [tlb_pkg::vppn_w-1:0]   r_vppn,
    output logic [tlb_pkg::ps_w-1:0]     r_ps,
    output logic [tlb_pkg::asid_w-1:0]   r_asid,
    output logic                         r_g,
    output logic [tlb_pkg::ppn_w-1:0]    r_ppn0,
    output logic [tlb_pkg::plv_w-1:0]    r_plv0,
    output logic [tlb_pkg::mat_w-1:0]    r_mat0,
    output logic                         r_d0,
    output logic                         r_v0,
    output logic [tlb_pkg::ppn_w-1:0]    r_ppn1,
    output logic [tlb_pkg::plv_w-1:0]    r_plv1,
    output logic [tlb_pkg::mat_w-1:0]    r_mat1,
    output logic                         r_d1,
    output logic                         r_v1
);
    import tlb_pkg::*;

    localparam int idx_w = $clog2(tlb_num);

    logic [tlb_num-1:0] inv_sel;

    // Entries picked by the current invtlb opcode.
    always_comb begin
        case (invtlb_op)
            inv_all0, inv_all1:    inv_sel = '1;
            inv_global:            inv_sel = ent.g;
            inv_nonglobal:         inv_sel = ~ent.g;
            inv_asid:              inv_sel = ~ent.g & ent.s1_asid_hit;
            inv_asid_va:           inv_sel = ~ent.g & ent.s1_asid_hit & ent.s1_vppn_hit;
            inv_global_or_asid_va: inv_sel = (ent.g | ent.s1_asid_hit) & ent.s1_vppn_hit;
            default:               inv_sel = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            ent.e <= '0;
        end else begin
            for (int i = 0; i < tlb_num; i++) begin
                if (we && w_index == idx_w'(i)) begin
                    ent.e[i] <= w_e; // A write beats invtlb on its own index.
                end else if (invtlb_valid && inv_sel[i]) begin
                    ent.e[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (we) begin
            ent.vppn[w_index] <= w_vppn;
            ent.ps[w_index]   <= w_ps;
            ent.asid[w_index] <= w_asid;
            ent.g[w_index]    <= w_g;
            ent.ppn0[w_index] <= w_ppn0;
            ent.plv0[w_index] <= w_plv0;
            ent.mat0[w_index] <= w_mat0;
            ent.d0[w_index]   <= w_d0;
            ent.v0[w_index]   <= w_v0;
            ent.ppn1[w_index] <= w_ppn1;
            ent.plv1[w_index] <= w_plv1;
            ent.mat1[w_index] <= w_mat1;
            ent.d1[w_index]   <= w_d1;
            ent.v1[w_index]   <= w_v1;
        end
    end

    assign r_e    = ent.e[r_index];
    assign r_vppn = ent.vppn[r_index];
    assign r_ps   = ent.ps[r_index];
    assign r_asid = ent.asid[r_index];
    assign r_g    = ent.g[r_index];
    assign r_ppn0 = ent.ppn0[r_index];
    assign r_plv0 = ent.plv0[r_index];
    assign r_mat0 = ent.mat0[r_index];
    assign r_d0   = ent.d0[r_index];
    assign r_v0   = ent.v0[r_index];
    assign r_ppn1 = ent.ppn1[r_index];
    assign r_plv1 = ent.plv1[r_index];
    assign r_mat1 = ent.mat1[r_index];
    assign r_d1   = ent.d1[r_index];
    assign r_v1   = ent.v1[r_index];

endmodule

/* source/tlb_pkg.sv */
package tlb_pkg;

    // Field widths of one TLB entry.
    localparam int vppn_w = 19;
    localparam int asid_w = 10;
    localparam int ppn_w  = 20;
    localparam int ps_w   = 6;
    localparam int plv_w  = 2;
    localparam int mat_w  = 2;

    // Supported page sizes, as log2 of the page size in bytes.
    localparam logic [ps_w-1:0] ps_4k = 6'd12;
    localparam logic [ps_w-1:0] ps_2m = 6'd21;

    // Invtlb opcodes.
    localparam logic [4:0] inv_all0              = 5'd0;
    localparam logic [4:0] inv_all1              = 5'd1;
    localparam logic [4:0] inv_global            = 5'd2;
    localparam logic [4:0] inv_nonglobal         = 5'd3;
    localparam logic [4:0] inv_asid              = 5'd4;
    localparam logic [4:0] inv_asid_va           = 5'd5;
    localparam logic [4:0] inv_global_or_asid_va = 5'd6;

endpackage

/* source/tlb_search_port.sv */
`timescale 1ns/1ps

module tlb_search_port #(
    parameter int tlb_num    = 16,
    parameter bit drive_hits = 1'b0
) (
    tlb_entry_if.search                  ent,
    input  logic [tlb_pkg::vppn_w-1:0]   vppn,
    input  logic                         va_bit12,
    input  logic [tlb_pkg::asid_w-1:0]   asid,
    output logic                         found,
    output logic [$clog2(tlb_num)-1:0]   index,
    output logic [tlb_pkg::ppn_w-1:0]    ppn,
    output logic [tlb_pkg::ps_w-1:0]     ps,
    output logic [tlb_pkg::plv_w-1:0]    plv,
    output logic [tlb_pkg::mat_w-1:0]    mat,
    output logic                         d,
    output logic                         v
);
    import tlb_pkg::*;

    localparam int idx_w = $clog2(tlb_num);

    logic [tlb_num-1:0] vppn_hit;
    logic [tlb_num-1:0] asid_hit;
    logic [tlb_num-1:0] match;
    logic               odd;

    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            if (ent.ps[i] == ps_4k) begin
                vppn_hit[i] = ent.vppn[i] == vppn;
            end else begin
                vppn_hit[i] = ent.vppn[i][vppn_w-1:9] == vppn[vppn_w-1:9]; // 2 MB page.
            end
            asid_hit[i] = ent.asid[i] == asid;
            match[i]    = ent.e[i] & (asid_hit[i] | ent.g[i]) & vppn_hit[i];
        end
    end

    // Scanning downward leaves the lowest matching index.
    always_comb begin
        found = 1'b0;
        index = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (match[i]) begin
                found = 1'b1;
                index = idx_w'(i);
            end
        end
    end

    generate
        if (drive_hits) begin : g_hits
            assign ent.s1_vppn_hit = vppn_hit;
            assign ent.s1_asid_hit = asid_hit;
        end
    endgenerate

    // Even or odd half of the page pair.
    assign odd = (ent.ps[index] == ps_4k) ? va_bit12 : vppn[8];

    assign ps  = ent.ps[index];
    assign ppn = odd ? ent.ppn1[index] : ent.ppn0[index];
    assign plv = odd ? ent.plv1[index] : ent.plv0[index];
    assign mat = odd ? ent.mat1[index] : ent.mat0[index];
    assign d   = odd ? ent.d1[index] : ent.d0[index];
    assign v   = odd ? ent.v1[index] : ent.v0[index];

endmodule

/* source/tlb_top.sv */
`timescale 1ns/1ps

module tlb_top #(
    parameter int tlb_num = 16
) (
    input  logic                         aclk,
    input  logic                         reset,

    input  logic [tlb_pkg::vppn_w-1:0]   s0_vppn,
    input  logic                         s0_va_bit12,
    input  logic [tlb_pkg::asid_w-1:0]   s0_asid,
    output logic                         s0_found,
    output logic [$clog2(tlb_num)-1:0]   s0_index,
    output logic [tlb_pkg::ppn_w-1:0]    s0_ppn,
    output logic [tlb_pkg::ps_w-1:0]     s0_ps,
    output logic [tlb_pkg::plv_w-1:0]    s0_plv,
    output logic [tlb_pkg::mat_w-1:0]    s0_mat,
    output logic                         s0_d,
    output logic                         s0_v,

    input  logic [tlb_pkg::vppn_w-1:0]   s1_vppn,
    input  logic                         s1_va_bit12,
    input  logic [tlb_pkg::asid_w-1:0]   s1_asid,
    output logic                         s1_found,
    output logic [$clog2(tlb_num)-1:0]   s1_index,
    output logic [tlb_pkg::ppn_w-1:0]    s1_ppn,
    output logic [tlb_pkg::ps_w-1:0]     s1_ps,
    output logic [tlb_pkg::plv_w-1:0]    s1_plv,
    output logic [tlb_pkg::mat_w-1:0]    s1_mat,
    output logic                         s1_d,
    output logic                         s1_v,

    input  logic                         invtlb_valid,
    input  logic [4:0]                   invtlb_op,

    input  logic                         we,
    input  logic [$clog2(tlb_num)-1:0]   w_index,
    input  logic                         w_e,
    input  logic [tlb_pkg::vppn_w-1:0]   w_vppn,
    input  logic [tlb_pkg::ps_w-1:0]     w_ps,
    input  logic [tlb_pkg::asid_w-1:0]   w_asid,
    input  logic                         w_g,
    input  logic [tlb_pkg::ppn_w-1:0]    w_ppn0,
    input  logic [tlb_pkg::plv_w-1:0]    w_plv0,
    input  logic [tlb_pkg::mat_w-1:0]    w_mat0,
    input  logic                         w_d0,
    input  logic                         w_v0,
    input  logic [tlb_pkg::ppn_w-1:0]    w_ppn1,
    input  logic [tlb_pkg::plv_w-1:0]    w_plv1,
    input  logic [tlb_pkg::mat_w-1:0]    w_mat1,
    input  logic                         w_d1,
    input  logic                         w_v1,

    input  logic [$clog2(tlb_num)-1:0]   r_index,
    output logic                         r_e,
    output logic [tlb_pkg::vppn_w-1:0]   r_vppn,
    output logic [tlb_pkg::ps_w-1:0]     r_ps,
    output logic [tlb_pkg::asid_w-1:0]   r_asid,
    output logic                         r_g,
    output logic [tlb_pkg::ppn_w-1:0]    r_ppn0,
    output logic [tlb_pkg::plv_w-1:0]    r_plv0,
    output logic [tlb_pkg::mat_w-1:0]    r_mat0,
    output logic                         r_d0,
    output logic                         r_v0,
    output logic [tlb_pkg::ppn_w-1:0]    r_ppn1,
    output logic [tlb_pkg::plv_w-1:0]    r_plv1,
    output logic [tlb_pkg::mat_w-1:0]    r_mat1,
    output logic                         r_d1,
    output logic                         r_v1
);

    tlb_entry_if #(.tlb_num(tlb_num)) u_ent ();

    // Write, read and invtlb ports share their names with the top level.
    tlb_entry_store #(.tlb_num(tlb_num)) u_store (
        .ent (u_ent.store),
        .*
    );

    tlb_search_port #(.tlb_num(tlb_num), .drive_hits(1'b0)) u_search0 (
        .ent      (u_ent.search),
        .vppn     (s0_vppn     ),
        .va_bit12 (s0_va_bit12 ),
        .asid     (s0_asid     ),
        .found    (s0_found    ),
        .index    (s0_index    ),
        .ppn      (s0_ppn      ),
        .ps       (s0_ps       ),
        .plv      (s0_plv      ),
        .mat      (s0_mat      ),
        .d        (s0_d        ),
        .v        (s0_v        )
    );

    // Port 1 also supplies the ASID and VPPN hits that invtlb uses.
    tlb_search_port #(.tlb_num(tlb_num), .drive_hits(1'b1)) u_search1 (
        .ent      (u_ent.search),
        .vppn     (s1_vppn     ),
        .va_bit12 (s1_va_bit12 ),
        .asid     (s1_asid     ),
        .found    (s1_found    ),
        .index    (s1_index    ),
        .ppn      (s1_ppn      ),
        .ps       (s1_ps       ),
        .plv      (s1_plv      ),
        .mat      (s1_mat      ),
        .d        (s1_d        ),
        .v        (s1_v        )
    );

endmodule

/* testbench/tlb_sva.sv */
`timescale 1ns/1ps

module tlb_sva #(
    parameter int tlb_num = 16
) (
    input logic                               aclk,
    input logic                               reset,
    input logic [tlb_pkg::vppn_w-1:0]         s0_vppn, s1_vppn,
    input logic                               s0_va_bit12, s1_va_bit12,
    input logic [tlb_pkg::asid_w-1:0]         s0_asid, s1_asid,
    input logic                               s0_found, s1_found,
    input logic [$clog2(tlb_num)-1:0]         s0_index, s1_index,
    input logic [tlb_pkg::ppn_w-1:0]          s0_ppn, s1_ppn,
    input logic [tlb_pkg::ps_w-1:0]           s0_ps, s1_ps,
    input logic [tlb_pkg::plv_w-1:0]          s0_plv, s1_plv,
    input logic [tlb_pkg::mat_w-1:0]          s0_mat, s1_mat,
    input logic                               s0_d, s1_d, s0_v, s1_v,
    input logic                               invtlb_valid,
    input logic [4:0]                         invtlb_op,
    input logic                               we, w_e, w_g, w_d0, w_v0, w_d1, w_v1,
    input logic [$clog2(tlb_num)-1:0]         w_index, r_index,
    input logic [tlb_pkg::vppn_w-1:0]         w_vppn, r_vppn,
    input logic [tlb_pkg::ps_w-1:0]           w_ps, r_ps,
    input logic [tlb_pkg::asid_w-1:0]         w_asid, r_asid,
    input logic [tlb_pkg::ppn_w-1:0]          w_ppn0, w_ppn1, r_ppn0, r_ppn1,
    input logic [tlb_pkg::plv_w-1:0]          w_plv0, w_plv1, r_plv0, r_plv1,
    input logic [tlb_pkg::mat_w-1:0]          w_mat0, w_mat1, r_mat0, r_mat1,
    input logic                               r_e, r_g, r_d0, r_v0, r_d1, r_v1
);
    import tlb_pkg::*;

    int   fail_count = 0;
    logic seen_write;

    function automatic logic vmatch(input logic [18:0] ent, input logic [5:0] ps,
                                    input logic [18:0] va);
        if (ps == ps_4k) begin
            return ent == va;
        end
        return ent[18:9] == va[18:9]; // Large pages ignore the low nine bits.
    endfunction

    function automatic logic inv_rule(input logic [4:0] op, input logic g,
                                      input logic asid_hit, input logic vppn_hit);
        case (op)
            inv_all0, inv_all1:    return 1'b1;
            inv_global:            return g;
            inv_nonglobal:         return !g;
            inv_asid:              return !g && asid_hit;
            inv_asid_va:           return !g && asid_hit && vppn_hit;
            inv_global_or_asid_va: return (g || asid_hit) && vppn_hit;
            default:               return 1'b0;
        endcase
    endfunction

    logic [88:0]  w_all;
    logic [88:0]  r_all;
    logic [25:0]  page0;
    logic [25:0]  page1;
    logic [25:0]  s0_page;
    logic [25:0]  s1_page;
    logic [25:0]  exp0;
    logic [25:0]  exp1;
    logic         s0_ok;
    logic         s1_ok;
    logic         s1_asid_eq;
    logic         s1_vppn_eq;

    assign w_all = {w_e, w_vppn, w_ps, w_asid, w_g, w_ppn0, w_plv0, w_mat0, w_d0, w_v0,
                    w_ppn1, w_plv1, w_mat1, w_d1, w_v1};
    assign r_all = {r_e, r_vppn, r_ps, r_asid, r_g, r_ppn0, r_plv0, r_mat0, r_d0, r_v0,
                    r_ppn1, r_plv1, r_mat1, r_d1, r_v1};
    assign page0   = {r_ppn0, r_plv0, r_mat0, r_d0, r_v0};
    assign page1   = {r_ppn1, r_plv1, r_mat1, r_d1, r_v1};
    assign s0_page = {s0_ppn, s0_plv, s0_mat, s0_d, s0_v};
    assign s1_page = {s1_ppn, s1_plv, s1_mat, s1_d, s1_v};
    assign exp0 = ((r_ps == ps_4k) ? s0_va_bit12 : s0_vppn[8]) ? page1 : page0;
    assign exp1 = ((r_ps == ps_4k) ? s1_va_bit12 : s1_vppn[8]) ? page1 : page0;
    assign s0_ok = r_e && (r_g || s0_asid == r_asid) && vmatch(r_vppn, r_ps, s0_vppn);
    assign s1_ok = r_e && (r_g || s1_asid == r_asid) && vmatch(r_vppn, r_ps, s1_vppn);
    assign s1_asid_eq = s1_asid == r_asid;
    assign s1_vppn_eq = vmatch(r_vppn, r_ps, s1_vppn);

    always_ff @(posedge aclk) begin
        if (reset) begin
            seen_write <= 1'b0;
        end else if (we) begin
            seen_write <= 1'b1;
        end
    end

    a_idle: assert property (@(posedge aclk) disable iff (reset)
        !seen_write |-> !s0_found && !s1_found)
        else begin
            fail_count++;
            $error("CHECK FAILED s0_found %h s1_found %h exp 0", s0_found, s1_found);
        end

    a_read: assert property (@(posedge aclk) disable iff (reset)
        $past(we) && r_index == $past(w_index) |-> r_all == $past(w_all))
        else begin
            fail_count++;
            $error("CHECK FAILED r_all got %h exp %h", r_all, $past(w_all));
        end

    a_s0_found: assert property (@(posedge aclk) disable iff (reset)
        s0_found && s0_index == r_index |-> s0_ok && s0_page == exp0 && s0_ps == r_ps)
        else begin
            fail_count++;
            $error("CHECK FAILED s0_page got %h exp %h ok %h", s0_page, exp0, s0_ok);
        end

    a_s1_found: assert property (@(posedge aclk) disable iff (reset)
        s1_found && s1_index == r_index |-> s1_ok && s1_page == exp1 && s1_ps == r_ps)
        else begin
            fail_count++;
            $error("CHECK FAILED s1_page got %h exp %h ok %h", s1_page, exp1, s1_ok);
        end

    a_s0_hit: assert property (@(posedge aclk) disable iff (reset)
        s0_ok |-> s0_found && s0_index <= r_index)
        else begin
            fail_count++;
            $error("CHECK FAILED s0_found %h s0_index %h r_index %h", s0_found, s0_index,
                   r_index);
        end

    a_s1_hit: assert property (@(posedge aclk) disable iff (reset)
        s1_ok |-> s1_found && s1_index <= r_index)
        else begin
            fail_count++;
            $error("CHECK FAILED s1_found %h s1_index %h r_index %h", s1_found, s1_index,
                   r_index);
        end

    a_invtlb: assert property (@(posedge aclk) disable iff (reset)
        $past(invtlb_valid) && $past(r_e) && !$past(we) && r_index == $past(r_index)
        |-> r_e == !inv_rule($past(invtlb_op), $past(r_g), $past(s1_asid_eq),
                             $past(s1_vppn_eq)))
        else begin
            fail_count++;
            $error("CHECK FAILED r_e got %h after invtlb op %h", r_e, $past(invtlb_op));
        end

endmodule

bind tlb_top tlb_sva #(.tlb_num(tlb_num)) u_sva (.*);

/* testbench/tlb_tb.sv */
`timescale 1ns/1ps

module tlb_tb;
    import tlb_pkg::*;

    localparam int tlb_num = 16;
    localparam int idx_w   = $clog2(tlb_num);

    logic aclk;
    logic reset;
    logic [vppn_w-1:0] s0_vppn, s1_vppn;
    logic s0_va_bit12, s1_va_bit12;
    logic [asid_w-1:0] s0_asid, s1_asid;
    logic s0_found, s1_found;
    logic [idx_w-1:0] s0_index, s1_index;
    logic [ppn_w-1:0] s0_ppn, s1_ppn;
    logic [ps_w-1:0] s0_ps, s1_ps;
    logic [plv_w-1:0] s0_plv, s1_plv;
    logic [mat_w-1:0] s0_mat, s1_mat;
    logic s0_d, s1_d, s0_v, s1_v;
    logic invtlb_valid;
    logic [4:0] invtlb_op;
    logic we, w_e, w_g, w_d0, w_v0, w_d1, w_v1;
    logic [idx_w-1:0] w_index, r_index;
    logic [vppn_w-1:0] w_vppn, r_vppn;
    logic [ps_w-1:0] w_ps, r_ps;
    logic [asid_w-1:0] w_asid, r_asid;
    logic [ppn_w-1:0] w_ppn0, w_ppn1, r_ppn0, r_ppn1;
    logic [plv_w-1:0] w_plv0, w_plv1, r_plv0, r_plv1;
    logic [mat_w-1:0] w_mat0, w_mat1, r_mat0, r_mat1;
    logic r_e, r_g, r_d0, r_v0, r_d1, r_v1;

    logic [31:0]       lfsr_state;
    logic [vppn_w-1:0] ent_vppn [tlb_num];
    logic [asid_w-1:0] ent_asid [tlb_num];
    logic              ent_g [tlb_num];
    int                tests_run;

    tlb_top #(.tlb_num(tlb_num)) uut (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken.
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s.", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic write_entry(input int idx);
        logic [31:0] r;
        logic [31:0] lo;
        take_bits(6, r);
        take_bits(9, lo);
        @(negedge aclk);
        we      = 1'b1;
        w_index = idx_w'(idx);
        r_index = idx_w'(idx);
        w_e     = 1'b1;
        w_vppn  = {r[5:0], 4'(idx), lo[8:0]}; // Index bits keep every entry distinct.
        w_ps    = idx[0] ? ps_2m : ps_4k;
        take_bits(10, r);
        w_asid  = r[9:0];
        take_bits(1, r);
        w_g     = r[0];
        take_bits(20, r);
        w_ppn0  = r[19:0];
        take_bits(20, r);
        w_ppn1  = r[19:0];
        take_bits(12, r);
        {w_plv0, w_mat0, w_d0, w_v0, w_plv1, w_mat1, w_d1, w_v1} = r[11:0];
        ent_vppn[idx] = w_vppn;
        ent_asid[idx] = w_asid;
        ent_g[idx]    = w_g;
        @(negedge aclk);
        we = 1'b0;
    endtask

    task automatic fill_all();
        for (int i = 0; i < tlb_num; i++) begin
            write_entry(i);
        end
    endtask

    task automatic wait_search(input logic exp_found);
        int n;
        n = 0;
        @(posedge aclk);
        while (s0_found !== exp_found || s1_found !== exp_found) begin
            n++;
            if (n > 8) begin
                abort_run("a search result");
            end
            @(posedge aclk);
        end
    endtask

    task automatic search_entry(input int idx, input bit same_asid);
        logic [31:0] r;
        take_bits(11, r);
        @(negedge aclk);
        r_index     = idx_w'(idx);
        s0_vppn     = ent_vppn[idx];
        s1_vppn     = ent_vppn[idx];
        if (idx[0]) begin
            s0_vppn[8:0] = r[8:0]; // 2 MB page hits whatever the low bits are.
        end
        s0_va_bit12 = r[9];
        s1_va_bit12 = r[10];
        s0_asid     = same_asid ? ent_asid[idx] : ent_asid[idx] ^ 10'h155;
        s1_asid     = s0_asid;
        wait_search(same_asid | ent_g[idx]);
    endtask

    task automatic report(input string name);
        tests_run++;
        $display("test %0d %s finished, assertion failures so far %0d", tests_run, name,
                 uut.u_sva.fail_count);
    endtask

    initial begin
        #(40 * 20000);
        abort_run("the whole run to finish");
    end

    initial begin
        logic [31:0] r;
        lfsr_state = 32'h6ea443cb;
        tests_run = 0;
        reset = 1'b1;
        {s0_vppn, s0_va_bit12, s0_asid, s1_vppn, s1_va_bit12, s1_asid} = '0;
        {invtlb_valid, invtlb_op, we, w_index, w_e, w_vppn, w_ps, w_asid, w_g} = '0;
        {w_ppn0, w_plv0, w_mat0, w_d0, w_v0, w_ppn1, w_plv1, w_mat1, w_d1, w_v1} = '0;
        r_index = '0;
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;

        for (int i = 0; i < 8; i++) begin
            take_bits(19, r);
            @(negedge aclk);
            s0_vppn = r[18:0];
            s1_vppn = ~r[18:0];
            wait_search(1'b0);
        end
        report("idle after reset");

        fill_all();
        report("write and read back");

        for (int i = 0; i < tlb_num; i++) begin
            search_entry(i, 1'b1);
        end
        report("search hits, both page sizes");

        for (int i = 0; i < tlb_num; i++) begin
            search_entry(i, 1'b0);
        end
        report("asid and global rule");

        for (int op = 0; op < 7; op++) begin
            for (int k = 0; k < 3; k++) begin
                fill_all();
                take_bits(6, r);
                @(negedge aclk);
                r_index      = r[3:0];
                s1_vppn      = r[4] ? ent_vppn[r[3:0]] : ent_vppn[r[3:0]] ^ 19'h1000;
                s1_asid      = r[5] ? ent_asid[r[3:0]] : ent_asid[r[3:0]] ^ 10'h2aa;
                invtlb_valid = 1'b1;
                invtlb_op    = 5'(op);
                @(negedge aclk);
                invtlb_valid = 1'b0;
                @(negedge aclk);
            end
        end
        report("invtlb opcodes");

        $display("tests run %0d, assertion failures %0d", tests_run, uut.u_sva.fail_count);
        if (uut.u_sva.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
